// File: project.f
+incdir+include
hdl/ldpc_geom_pkg.sv
hdl/ldpc_graph_pkg.sv
hdl/ldpc_core_syndrome.sv
hdl/ldpc_core_parity.sv
hdl/ldpc_ext_parity.sv
hdl/ldpc_encoder_top.sv
verif/ldpc_encoder_tb.sv

// File: Bender.yml
package:
  name: ldpc_encoder

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ldpc_geom_pkg.sv
      - hdl/ldpc_graph_pkg.sv
      - hdl/ldpc_core_syndrome.sv
      - hdl/ldpc_core_parity.sv
      - hdl/ldpc_ext_parity.sv
      - hdl/ldpc_encoder_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/ldpc_encoder_tb.sv

// File: verif/ldpc_encoder_tb.sv
`timescale 1ns/1ps
`include "ldpc_defs.svh"

module ldpc_encoder_tb;

    localparam int core_lo = ldpc_geom_pkg::sys_bits;
    localparam int ext_lo = ldpc_geom_pkg::sys_bits + ldpc_geom_pkg::core_bits;

    logic CLK;
    logic RST;
    logic [3:0] data;
    logic [15:0] crc;
    logic start;
    ldpc_geom_pkg::codeword_t codeword;
    logic cw_valid;

    int seed;
    int value_errs;
    int proto_errs;
    int timeout_errs;
    bit seen_start;
    ldpc_geom_pkg::msg_t msg_q[$]; // messages still in flight, oldest first

    ldpc_encoder_top dut (
        .CLK(CLK), .RST(RST),
        .data(data), .crc(crc), .start(start),
        .codeword(codeword), .cw_valid(cw_valid)
    );

    always #50 CLK = ~CLK;

    // odd shifts swap the two bits of a block
    function automatic ldpc_geom_pkg::block_t rotate_block(
        input ldpc_geom_pkg::block_t b,
        input ldpc_geom_pkg::shift_t k
    );
        if (k == `LDPC_NULL_SHIFT) begin
            return '0;
        end else if (k % 2 == 0) begin
            return b;
        end else begin
            return {b[0], b[1]};
        end
    endfunction

    task automatic report_value(input string name, input logic [35:0] exp, input logic [35:0] act);
        value_errs++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    endtask

    task automatic check_codeword(input ldpc_geom_pkg::msg_t m, input ldpc_geom_pkg::codeword_t cw);
        ldpc_geom_pkg::block_t lam [`LDPC_CORE_ROWS];
        ldpc_geom_pkg::block_t par [`LDPC_CORE_ROWS];
        ldpc_geom_pkg::block_t lam_all;
        ldpc_geom_pkg::block_t acc;
        ldpc_geom_pkg::core_par_t exp_core;
        lam_all = '0;
        for (int r = 0; r < `LDPC_CORE_ROWS; r++) begin
            lam[r] = '0;
            for (int j = 0; j < `LDPC_KB; j++) begin
                lam[r] = lam[r] ^ rotate_block(m[2*j +: 2], ldpc_graph_pkg::a_table[r][j]);
            end
            lam_all = lam_all ^ lam[r];
        end
        // double diagonal, corner shift of one
        par[0] = rotate_block(lam_all, 4'd1);
        par[1] = par[0] ^ lam[0];
        par[3] = par[0] ^ lam[3];
        par[2] = par[1] ^ lam[1];
        exp_core = {par[3], par[2], par[1], par[0]};

        assert (cw[core_lo-1:0] == m[19:4])
            else report_value("systematic", m[19:4], cw[core_lo-1:0]);
        assert (cw[ext_lo-1:core_lo] == exp_core)
            else report_value("core_parity", exp_core, cw[ext_lo-1:core_lo]);

        // each extension row must sum to zero
        for (int r = 0; r < `LDPC_EXT_ROWS; r++) begin
            acc = cw[ext_lo + 2*r +: 2];
            for (int j = 0; j < `LDPC_KB; j++) begin
                acc = acc ^ rotate_block(m[2*j +: 2], ldpc_graph_pkg::c_table[r][j]);
            end
            for (int i = 0; i < `LDPC_CORE_ROWS; i++) begin
                acc = acc ^ rotate_block(par[i], ldpc_graph_pkg::d_table[r][i]);
            end
            assert (acc == '0)
                else report_value($sformatf("ext_row%0d", r), '0, acc);
        end
    endtask

    // outputs settle after the rising edge, so look at the falling one
    always @(negedge CLK) begin
        if (RST && cw_valid) begin
            if (msg_q.size() == 0) begin
                proto_errs++;
                $display("protocol: cw_valid came with no encode outstanding");
            end else begin
                check_codeword(msg_q.pop_front(), codeword);
            end
        end
    end

    a_latency: assert property (
        @(posedge CLK) disable iff (!RST)
        start |-> ##3 cw_valid
    ) else begin
        proto_errs++;
        $display("protocol: cw_valid did not follow start by three cycles");
    end

    a_no_extra_valid: assert property (
        @(posedge CLK) disable iff (!RST)
        cw_valid |-> $past(start, 3)
    ) else begin
        proto_errs++;
        $display("protocol: cw_valid without a start three cycles before");
    end

    a_reset_idle: assert property (
        @(posedge CLK)
        !seen_start |-> (!cw_valid && codeword == '0)
    ) else begin
        proto_errs++;
        $display("reset: outputs not idle before the first encode");
    end

    task automatic finish_run();
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errs, proto_errs, timeout_errs);
        if (value_errs + proto_errs + timeout_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic drive_encode(input logic [3:0] d, input logic [15:0] c);
        @(posedge CLK);
        data <= d;
        crc <= c;
        start <= 1'b1;
        seen_start <= 1'b1;
        msg_q.push_back({c, d});
    endtask

    task automatic send_random();
        logic [31:0] r;
        r = $random(seed);
        drive_encode(r[3:0], r[19:4] ^ r[31:16]);
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge CLK);
            start <= 1'b0;
        end
    endtask

    task automatic wait_cw(input string what, input int limit);
        int n;
        n = 0;
        @(negedge CLK);
        while (!cw_valid && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (!cw_valid) begin
            timeout_errs++;
            $display("timeout: no cw_valid within %0d cycles for %s", limit, what);
            finish_run();
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (msg_q.size() != 0 && n < limit) begin
            @(posedge CLK);
            n++;
        end
        if (msg_q.size() != 0) begin
            timeout_errs++;
            $display("timeout: %0d encodes still pending after the burst", msg_q.size());
            finish_run();
        end
    endtask

    initial begin
        CLK = 1'b0;
        RST = 1'b0;
        data = '0;
        crc = '0;
        start = 1'b0;
        seen_start = 1'b0;
        seed = 32'h96ed_c734;
        value_errs = 0;
        proto_errs = 0;
        timeout_errs = 0;

        repeat (16) @(posedge CLK);
        RST <= 1'b1;
        drive_idle(4); // outputs must stay idle here too

        // corner messages
        drive_encode(4'h0, 16'h0000);
        drive_idle(1);
        wait_cw("all-zero encode", 10);
        drive_encode(4'hf, 16'hffff);
        drive_idle(1);
        wait_cw("all-ones encode", 10);

        // isolated encodes
        for (int k = 0; k < 8; k++) begin
            send_random();
            drive_idle(1);
            wait_cw("single random encode", 10);
        end

        // back to back, three in flight
        for (int k = 0; k < 12; k++) begin
            send_random();
        end
        drive_idle(2);
        wait_drain(20);

        // short bursts with gaps
        for (int k = 0; k < 4; k++) begin
            send_random();
            send_random();
            drive_idle(k + 1);
        end
        wait_drain(20);

        drive_idle(4);
        finish_run();
    end

endmodule

// File: hdl/ldpc_encoder_top.sv
`timescale 1ns/1ps
`include "ldpc_defs.svh"

module ldpc_encoder_top (
    input  logic                                            CLK,
    input  logic                                            RST,
    input  logic [`LDPC_PUNCT_COLS*`LDPC_ZC-1:0]            data,
    input  logic [(`LDPC_KB-`LDPC_PUNCT_COLS)*`LDPC_ZC-1:0] crc,
    input  logic                                            start,
    output ldpc_geom_pkg::codeword_t                        codeword,
    output logic                                            cw_valid
);

    // stage 1 to stage 2
    ldpc_geom_pkg::msg_t syn_msg;
    ldpc_geom_pkg::block_t [`LDPC_CORE_ROWS-1:0] lambda;
    logic syn_valid;

    // stage 2 to stage 3
    ldpc_geom_pkg::msg_t par_msg;
    ldpc_geom_pkg::core_par_t core_par;
    logic par_valid;

    ldpc_core_syndrome u_syndrome (
        .CLK(CLK), .RST(RST),
        .data(data), .crc(crc), .start(start),
        .syn_msg(syn_msg), .lambda(lambda), .syn_valid(syn_valid)
    );

    ldpc_core_parity u_core_parity (
        .CLK(CLK), .RST(RST),
        .syn_msg(syn_msg), .lambda(lambda), .syn_valid(syn_valid),
        .par_msg(par_msg), .core_par(core_par), .par_valid(par_valid)
    );

    ldpc_ext_parity u_ext_parity (
        .CLK(CLK), .RST(RST),
        .par_msg(par_msg), .core_par(core_par), .par_valid(par_valid),
        .codeword(codeword), .cw_valid(cw_valid)
    );

endmodule

// File: hdl/ldpc_ext_parity.sv
`timescale 1ns/1ps
`include "ldpc_defs.svh"

module ldpc_ext_parity (
    input  logic                     CLK,
    input  logic                     RST,
    input  ldpc_geom_pkg::msg_t      par_msg,
    input  ldpc_geom_pkg::core_par_t core_par,
    input  logic                     par_valid,
    output ldpc_geom_pkg::codeword_t codeword,
    output logic                     cw_valid
);

    ldpc_geom_pkg::block_t [`LDPC_EXT_ROWS-1:0] ext_nxt;
    ldpc_geom_pkg::codeword_t cw_nxt;

    // each extension block closes its own check row
    always_comb begin
        ext_nxt = '0;
        for (int r = 0; r < `LDPC_EXT_ROWS; r++) begin
            for (int j = 0; j < `LDPC_KB; j++) begin
                ext_nxt[r] = ext_nxt[r] ^ ldpc_graph_pkg::circ_shift(
                    par_msg[j*`LDPC_ZC +: `LDPC_ZC], ldpc_graph_pkg::c_table[r][j]);
            end
            for (int i = 0; i < `LDPC_CORE_ROWS; i++) begin
                ext_nxt[r] = ext_nxt[r] ^ ldpc_graph_pkg::circ_shift(
                    core_par[i*`LDPC_ZC +: `LDPC_ZC], ldpc_graph_pkg::d_table[r][i]);
            end
        end
    end

    // punctured blocks 0 and 1 are not sent
    assign cw_nxt = {
        ext_nxt,
        core_par,
        par_msg[`LDPC_KB*`LDPC_ZC-1:`LDPC_PUNCT_COLS*`LDPC_ZC]
    };

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            codeword <= '0;
            cw_valid <= 1'b0;
        end else begin
            cw_valid <= par_valid;
            if (par_valid) begin
                codeword <= cw_nxt; // held until the next encode
            end
        end
    end

    // whole pipeline must deliver clean bits
    a_cw_known: assert property (
        @(posedge CLK) disable iff (!RST)
        cw_valid |-> !$isunknown(codeword)
    );

endmodule

// File: hdl/ldpc_core_parity.sv
`timescale 1ns/1ps
`include "ldpc_defs.svh"

module ldpc_core_parity (
    input  logic                                        CLK,
    input  logic                                        RST,
    input  ldpc_geom_pkg::msg_t                         syn_msg,
    input  ldpc_geom_pkg::block_t [`LDPC_CORE_ROWS-1:0] lambda,
    input  logic                                        syn_valid,
    output ldpc_geom_pkg::msg_t                         par_msg,
    output ldpc_geom_pkg::core_par_t                    core_par,
    output logic                                        par_valid
);

    // B corner entry of this graph is a shift of one
    localparam ldpc_geom_pkg::shift_t diag_shift = 4'd1;

    ldpc_geom_pkg::block_t lam_sum;
    ldpc_geom_pkg::block_t [`LDPC_CORE_ROWS-1:0] par_nxt;

    // double-diagonal solve, p0 first then the chain
    always_comb begin
        lam_sum = '0;
        for (int r = 0; r < `LDPC_CORE_ROWS; r++) begin
            lam_sum = lam_sum ^ lambda[r];
        end
        par_nxt[0] = ldpc_graph_pkg::circ_shift(lam_sum, diag_shift);
        par_nxt[1] = par_nxt[0] ^ lambda[0];
        par_nxt[3] = par_nxt[0] ^ lambda[3];
        par_nxt[2] = par_nxt[1] ^ lambda[1]; // row 1 closes via p1
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            par_msg <= '0;
            core_par <= '0;
            par_valid <= 1'b0;
        end else begin
            par_valid <= syn_valid;
            if (syn_valid) begin
                par_msg <= syn_msg;
                core_par <= par_nxt;
            end
        end
    end

endmodule

// File: hdl/ldpc_core_syndrome.sv
`timescale 1ns/1ps
`include "ldpc_defs.svh"

module ldpc_core_syndrome (
    input  logic                                          CLK,
    input  logic                                          RST,
    input  logic [`LDPC_PUNCT_COLS*`LDPC_ZC-1:0]          data,
    input  logic [(`LDPC_KB-`LDPC_PUNCT_COLS)*`LDPC_ZC-1:0] crc,
    input  logic                                          start,
    output ldpc_geom_pkg::msg_t                           syn_msg,
    output ldpc_geom_pkg::block_t [`LDPC_CORE_ROWS-1:0]   lambda,
    output logic                                          syn_valid
);

    ldpc_geom_pkg::msg_t msg;
    ldpc_geom_pkg::block_t [`LDPC_CORE_ROWS-1:0] lambda_nxt;

    assign msg = {crc, data}; // data lands in blocks 0 and 1

    // one syndrome per core row, all ten columns folded in
    always_comb begin
        lambda_nxt = '0;
        for (int r = 0; r < `LDPC_CORE_ROWS; r++) begin
            for (int j = 0; j < `LDPC_KB; j++) begin
                lambda_nxt[r] = lambda_nxt[r] ^ ldpc_graph_pkg::circ_shift(
                    msg[j*`LDPC_ZC +: `LDPC_ZC], ldpc_graph_pkg::a_table[r][j]);
            end
        end
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            syn_msg <= '0;
            lambda <= '0;
            syn_valid <= 1'b0;
        end else begin
            syn_valid <= start;
            if (start) begin
                syn_msg <= msg;
                lambda <= lambda_nxt;
            end
        end
    end

    // strobe is exactly the input strobe delayed by one cycle
    a_syn_after_start: assert property (
        @(posedge CLK) disable iff (!RST)
        syn_valid |-> $past(start)
    );

endmodule

// File: hdl/ldpc_graph_pkg.sv
`include "ldpc_defs.svh"

package ldpc_graph_pkg;

    // short names keep the tables readable
    localparam ldpc_geom_pkg::shift_t s0 = 4'd0;
    localparam ldpc_geom_pkg::shift_t s1 = 4'd1;
    localparam ldpc_geom_pkg::shift_t sx = `LDPC_NULL_SHIFT;

    // core rows over the message columns
    localparam ldpc_geom_pkg::shift_t a_table [`LDPC_CORE_ROWS][`LDPC_KB] = '{
        '{s1, s1, s0, s0, sx, sx, s1, sx, sx, s1},
        '{s1, sx, sx, s0, s1, s1, s0, s0, s0, s0},
        '{s1, s0, sx, s0, s0, sx, sx, sx, s0, sx},
        '{sx, s0, s0, sx, s0, s0, s1, s0, s0, s0}
    };

    // extension rows over the message columns
    localparam ldpc_geom_pkg::shift_t c_table [`LDPC_EXT_ROWS][`LDPC_KB] = '{
        '{s1, s0, sx, sx, sx, sx, sx, sx, sx, sx},
        '{s1, s1, sx, sx, sx, s0, sx, s1, sx, sx},
        '{s1, sx, sx, sx, sx, s0, sx, s1, sx, s0},
        '{sx, s1, sx, sx, sx, s1, sx, s0, sx, sx},
        '{s0, s0, sx, sx, sx, sx, sx, sx, sx, sx},
        '{sx, s1, sx, sx, sx, sx, sx, sx, s1, sx}
    };

    // extension rows over the core parity columns
    localparam ldpc_geom_pkg::shift_t d_table [`LDPC_EXT_ROWS][`LDPC_CORE_ROWS] = '{
        '{sx, s1, sx, sx},
        '{sx, s1, sx, sx},
        '{sx, s0, sx, sx},
        '{sx, s1, sx, s0},
        '{sx, sx, s0, sx},
        '{s1, s1, sx, sx}
    };

    // bit m of the result is bit (m+k) mod ZC of blk
    function automatic ldpc_geom_pkg::block_t circ_shift(
        input ldpc_geom_pkg::block_t blk,
        input ldpc_geom_pkg::shift_t k
    );
        ldpc_geom_pkg::block_t rot;
        rot = '0;
        if (k != `LDPC_NULL_SHIFT) begin
            for (int m = 0; m < `LDPC_ZC; m++) begin
                rot[m] = blk[(m + k) % `LDPC_ZC];
            end
        end
        return rot;
    endfunction

endpackage

// File: hdl/ldpc_geom_pkg.sv
`include "ldpc_defs.svh"

package ldpc_geom_pkg;

    // one lifted block of ZC bits
    typedef logic [`LDPC_ZC-1:0] block_t;

    // block j sits in bits ZC*j+ZC-1 down to ZC*j
    typedef logic [`LDPC_KB*`LDPC_ZC-1:0] msg_t;

    typedef logic [3:0] shift_t; // circulant shift, null code included

    // core parity blocks 0..3, block 0 lowest
    typedef logic [`LDPC_CORE_ROWS*`LDPC_ZC-1:0] core_par_t;

    // sent systematic part, core parity, extension parity
    localparam int sys_bits = (`LDPC_KB - `LDPC_PUNCT_COLS) * `LDPC_ZC;
    localparam int core_bits = `LDPC_CORE_ROWS * `LDPC_ZC;
    localparam int ext_bits = `LDPC_EXT_ROWS * `LDPC_ZC;
    localparam int cw_bits = sys_bits + core_bits + ext_bits;

    // ext parity on top, systematic blocks 2..9 at the bottom
    typedef logic [cw_bits-1:0] codeword_t;

endpackage

// File: include/ldpc_defs.svh
`ifndef LDPC_DEFS_SVH
`define LDPC_DEFS_SVH

// lifting size of every circulant
`define LDPC_ZC 2

// information columns of the small base graph
`define LDPC_KB 10

// core rows are solved by the double diagonal
`define LDPC_CORE_ROWS 4

// extension rows kept
`define LDPC_EXT_ROWS 6

`define LDPC_NULL_SHIFT 4'd15 // all-zero circulant

// leading systematic columns left out of the codeword
`define LDPC_PUNCT_COLS 2

`endif
